// File: hw/mtimer_consts.svh
/* register map, widths and timebase constants for the machine timer,
   included by the package and by every RTL module */

`ifndef MTIMER_CONSTS_SVH
`define MTIMER_CONSTS_SVH

// ----------------------------------------------------------------------
// bus and hart sizing

`define MTIMER_ADDR_W 16
`define MTIMER_DATA_W 32
`define MTIMER_N_HARTS 2

// clocks per mtime tick, reference clock is 27 MHz so one tick per us
`define MTIMER_TICK_DIV 27

// ----------------------------------------------------------------------
// register offsets

// bit 0 enables counting
`define MTIMER_OFS_CTRL 16'h0000
// one bit per hart
`define MTIMER_OFS_MSIP 16'h0004
`define MTIMER_OFS_MTIME 16'h0008
`define MTIMER_OFS_MTIMEH 16'h000c
// hart h compare pair at base + 8*h, low word first
`define MTIMER_OFS_CMP_BASE 16'h0010

`endif

// File: hw/mtimer_pkg.sv
/* shared types for the timer: register offset views, op kind and
   AXI response codes */

`default_nettype none

`include "mtimer_consts.svh"

package mtimer_pkg;

	// hart index field width, at least one bit
	localparam int HART_IDX_W = (`MTIMER_N_HARTS > 1) ? $clog2(`MTIMER_N_HARTS) : 1;
	// whatever is left above hart index, hi/lo select and byte field
	localparam int OFS_UPPER_W = `MTIMER_ADDR_W - HART_IDX_W - 3;

	// ------------------------------------------------------------------
	// register offset, seen as raw word or as compare-register fields

	typedef union packed {
		// raw view for exact matches on the fixed registers
		logic [`MTIMER_ADDR_W-1:0] raw;
		// field view for the mtimecmp block
		struct packed {
			logic [OFS_UPPER_W-1:0] upper;
			logic [HART_IDX_W-1:0]  hart;
			logic                   hi;
			logic [1:0]             byte_sel;
		} f;
	} mtimer_ofs_u;

	// op slot contents, none means idle cycle
	typedef enum logic [1:0] {
		MTIMER_OP_NONE  = 2'd0,
		MTIMER_OP_WRITE = 2'd1,
		MTIMER_OP_READ  = 2'd2
	} mtimer_op_e;

	// AXI4-Lite bresp/rresp encodings
	typedef enum logic [1:0] {
		MTIMER_RESP_OKAY   = 2'b00,
		MTIMER_RESP_SLVERR = 2'b10
	} mtimer_resp_e;

endpackage

`default_nettype wire

// File: hw/mtimer_req_decode.sv
/* AXI4-Lite request side: arbitrates write over read and loads the
   accepted request into a single op slot for the execute stage */

`timescale 1ns/100ps
`default_nettype none

`include "mtimer_consts.svh"

module mtimer_req_decode import mtimer_pkg::*; (
	input  wire                            clk,
	input  wire                            rst_n,

	// AXI4-Lite request channels
	input  wire                            i_s_awvalid,
	input  wire  [`MTIMER_ADDR_W-1:0]      i_s_awaddr,
	input  wire                            i_s_wvalid,
	input  wire  [`MTIMER_DATA_W-1:0]      i_s_wdata,
	input  wire  [`MTIMER_DATA_W/8-1:0]    i_s_wstrb,
	input  wire                            i_s_arvalid,
	input  wire  [`MTIMER_ADDR_W-1:0]      i_s_araddr,

	// response still held by the result stage
	input  logic                           i_busy,

	output logic                           o_s_awready,
	output logic                           o_s_wready,
	output logic                           o_s_arready,

	// op slot, valid for one cycle
	output mtimer_op_e                     o_op,
	output mtimer_ofs_u                    o_ofs,
	output logic [`MTIMER_DATA_W-1:0]      o_wdata,
	output logic [`MTIMER_DATA_W/8-1:0]    o_wstrb
);

	// nothing in the op slot and no response waiting
	logic idle;
	// write takes aw and w in the same cycle
	logic w_take;
	// read only when no write can go
	logic r_take;

	// ------------------------------------------------------------------
	// arbitration

	assign idle   = !i_busy && (o_op == MTIMER_OP_NONE);
	assign w_take = idle && i_s_awvalid && i_s_wvalid;
	assign r_take = idle && i_s_arvalid && !w_take;

	// aw and w accepted together
	assign o_s_awready = w_take;
	assign o_s_wready  = w_take;
	assign o_s_arready = r_take;

	// ------------------------------------------------------------------
	// op slot

	// op kind is control state, one-cycle strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_op <= MTIMER_OP_NONE;
		end else if (w_take) begin
			o_op <= MTIMER_OP_WRITE;
		end else if (r_take) begin
			o_op <= MTIMER_OP_READ;
		end else begin
			o_op <= MTIMER_OP_NONE;
		end
	end

	// payload, only meaningful while o_op is not none
	always_ff @(posedge clk) begin
		if (w_take) begin
			o_ofs.raw <= i_s_awaddr;
			o_wdata   <= i_s_wdata;
			o_wstrb   <= i_s_wstrb;
		end else if (r_take) begin
			o_ofs.raw <= i_s_araddr;
			// read ignores write data, strobes cleared
			o_wstrb   <= '0;
		end
	end

	// ------------------------------------------------------------------
	// checks

	// accept only when result is free, then op next cycle and
	// the result stage holds a response the cycle after
	a_accept_flow: assert property (
		@(posedge clk) disable iff (!rst_n)
		((i_s_awvalid && o_s_awready) || (i_s_arvalid && o_s_arready))
		|-> !i_busy ##1 (o_op != MTIMER_OP_NONE) ##1 i_busy
	);

endmodule

`default_nettype wire

// File: hw/mtimer_exec.sv
/* timer state: microsecond prescaler, mtime, enable, msip and per-hart
   mtimecmp; performs the register access of each op in its cycle */

`timescale 1ns/100ps
`default_nettype none

`include "mtimer_consts.svh"

module mtimer_exec import mtimer_pkg::*; (
	input  wire                            clk,
	input  wire                            rst_n,

	// op slot from decode
	input  mtimer_op_e                     i_op,
	input  mtimer_ofs_u                    i_ofs,
	input  logic [`MTIMER_DATA_W-1:0]      i_wdata,
	input  logic [`MTIMER_DATA_W/8-1:0]    i_wstrb,

	// all bits high freezes mtime
	input  wire  [`MTIMER_N_HARTS-1:0]     i_hart_halted,

	output logic [`MTIMER_DATA_W-1:0]      o_rdata,
	output logic                           o_unmapped,
	output logic [`MTIMER_N_HARTS-1:0]     o_soft_irq,
	output logic [`MTIMER_N_HARTS-1:0]     o_timer_irq
);

	localparam int DW     = `MTIMER_DATA_W;
	localparam int NH     = `MTIMER_N_HARTS;
	localparam int TICK_W = $clog2(`MTIMER_TICK_DIV);
	// upper field value that marks the compare block
	localparam logic [OFS_UPPER_W-1:0] CMP_UPPER =
		OFS_UPPER_W'(`MTIMER_OFS_CMP_BASE >> (HART_IDX_W + 3));

	// per byte lane merge of write data over current contents
	function automatic logic [DW-1:0] merge_bytes(
		input logic [DW-1:0]   old_w,
		input logic [DW-1:0]   new_w,
		input logic [DW/8-1:0] strb
	);
		logic [DW-1:0] res;
		res = old_w;
		for (int b = 0; b < DW/8; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	logic [TICK_W-1:0]     tick_ctr;
	logic                  tick;
	logic                  count_en;
	logic                  ctrl_en;
	logic [NH-1:0]         msip;
	logic [2*DW-1:0]       mtime;
	logic [2*DW-1:0]       mtimecmp [NH];

	// register selects
	logic                  sel_ctrl;
	logic                  sel_msip;
	logic                  sel_mtime_lo;
	logic                  sel_mtime_hi;
	logic                  sel_cmp;
	logic [HART_IDX_W-1:0] cmp_hart;
	logic                  do_write;
	logic [DW-1:0]         rd_word;
	logic [DW-1:0]         wr_word;

	// ------------------------------------------------------------------
	// timebase

	// down counter, tick when it hits zero
	assign tick     = (tick_ctr == '0);
	// frozen only while every hart sits in debug
	assign count_en = tick && ctrl_en && !(&i_hart_halted);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= TICK_W'(`MTIMER_TICK_DIV - 1);
		end else if (tick) begin
			tick_ctr <= TICK_W'(`MTIMER_TICK_DIV - 1);
		end else begin
			tick_ctr <= tick_ctr - 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// offset decode

	// fixed registers by raw match
	assign sel_ctrl     = (i_ofs.raw == `MTIMER_OFS_CTRL);
	assign sel_msip     = (i_ofs.raw == `MTIMER_OFS_MSIP);
	assign sel_mtime_lo = (i_ofs.raw == `MTIMER_OFS_MTIME);
	assign sel_mtime_hi = (i_ofs.raw == `MTIMER_OFS_MTIMEH);
	// compare block by fields, word aligned, hart in range
	assign sel_cmp = (i_ofs.f.upper == CMP_UPPER) && (i_ofs.f.byte_sel == 2'b00) &&
		({1'b0, i_ofs.f.hart} < (HART_IDX_W + 1)'(NH));
	assign cmp_hart = i_ofs.f.hart;

	assign o_unmapped = !(sel_ctrl || sel_msip || sel_mtime_lo || sel_mtime_hi || sel_cmp);
	assign do_write   = (i_op == MTIMER_OP_WRITE) && !o_unmapped;

	// current contents at the offset, zero when unmapped
	always_comb begin
		rd_word = '0;
		if (sel_ctrl) begin
			rd_word[0] = ctrl_en;
		end else if (sel_msip) begin
			rd_word[NH-1:0] = msip;
		end else if (sel_mtime_lo) begin
			rd_word = mtime[DW-1:0];
		end else if (sel_mtime_hi) begin
			rd_word = mtime[2*DW-1:DW];
		end else if (sel_cmp) begin
			rd_word = i_ofs.f.hi ? mtimecmp[cmp_hart][2*DW-1:DW] : mtimecmp[cmp_hart][DW-1:0];
		end
	end

	assign wr_word = merge_bytes(rd_word, i_wdata, i_wstrb);
	assign o_rdata = rd_word;

	// ------------------------------------------------------------------
	// register state

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= 1'b0;
			msip    <= '0;
			mtime   <= '0;
			// all ones keeps every timer irq low
			for (int h = 0; h < NH; h++) begin
				mtimecmp[h] <= '1;
			end
		end else begin
			if (do_write && sel_ctrl) begin
				ctrl_en <= wr_word[0];
			end
			if (do_write && sel_msip) begin
				msip <= wr_word[NH-1:0];
			end
			// bus write beats the tick in the same cycle
			if (do_write && sel_mtime_lo) begin
				mtime[DW-1:0] <= wr_word;
			end else if (do_write && sel_mtime_hi) begin
				mtime[2*DW-1:DW] <= wr_word;
			end else if (count_en) begin
				mtime <= mtime + 1'b1;
			end
			if (do_write && sel_cmp) begin
				if (i_ofs.f.hi) begin
					mtimecmp[cmp_hart][2*DW-1:DW] <= wr_word;
				end else begin
					mtimecmp[cmp_hart][DW-1:0] <= wr_word;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// interrupts

	assign o_soft_irq = msip;

	for (genvar h = 0; h < NH; h++) begin : g_timer_irq
		// unsigned 64 bit compare
		assign o_timer_irq[h] = (mtime >= mtimecmp[h]);

		// mtime only counts up, so without a bus write a raised irq stays
		a_irq_hold: assert property (
			@(posedge clk) disable iff (!rst_n)
			(o_timer_irq[h] && (i_op != MTIMER_OP_WRITE)) |=> o_timer_irq[h]
		);
	end

endmodule

`default_nettype wire

// File: hw/mtimer_resp.sv
/* AXI4-Lite response side: registers each op's result and holds B or R
   until the master takes it; busy stalls decode meanwhile */

`timescale 1ns/100ps
`default_nettype none

`include "mtimer_consts.svh"

module mtimer_resp import mtimer_pkg::*; (
	input  wire                            clk,
	input  wire                            rst_n,

	// op strobe and access result
	input  mtimer_op_e                     i_op,
	input  logic [`MTIMER_DATA_W-1:0]      i_rdata,
	input  logic                           i_unmapped,

	input  wire                            i_s_bready,
	input  wire                            i_s_rready,

	output logic                           o_s_bvalid,
	output logic [1:0]                     o_s_bresp,
	output logic                           o_s_rvalid,
	output logic [`MTIMER_DATA_W-1:0]      o_s_rdata,
	output logic [1:0]                     o_s_rresp,

	// response pending
	output logic                           o_busy
);

	mtimer_resp_e bresp_q;
	mtimer_resp_e rresp_q;

	// ------------------------------------------------------------------
	// valid flags

	// decode never issues while busy, so set and clear cannot collide
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_s_bvalid <= 1'b0;
			o_s_rvalid <= 1'b0;
		end else begin
			if (i_op == MTIMER_OP_WRITE) begin
				o_s_bvalid <= 1'b1;
			end else if (i_s_bready) begin
				o_s_bvalid <= 1'b0;
			end
			if (i_op == MTIMER_OP_READ) begin
				o_s_rvalid <= 1'b1;
			end else if (i_s_rready) begin
				o_s_rvalid <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------
	// payload

	always_ff @(posedge clk) begin
		if (i_op == MTIMER_OP_WRITE) begin
			bresp_q <= i_unmapped ? MTIMER_RESP_SLVERR : MTIMER_RESP_OKAY;
		end
		if (i_op == MTIMER_OP_READ) begin
			// exec already zeroes unmapped reads
			o_s_rdata <= i_rdata;
			rresp_q   <= i_unmapped ? MTIMER_RESP_SLVERR : MTIMER_RESP_OKAY;
		end
	end

	assign o_s_bresp = bresp_q;
	assign o_s_rresp = rresp_q;
	assign o_busy    = o_s_bvalid || o_s_rvalid;

	// ------------------------------------------------------------------
	// checks

	// held B stays up and unchanged until bready
	a_b_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		(o_s_bvalid && !i_s_bready) |=> (o_s_bvalid && $stable(o_s_bresp))
	);

	// held R stays up and unchanged until rready
	a_r_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		(o_s_rvalid && !i_s_rready) |=>
			(o_s_rvalid && $stable(o_s_rdata) && $stable(o_s_rresp))
	);

endmodule

`default_nettype wire

// File: hw/mtimer_top.sv
/* machine timer behind an AXI4-Lite slave port; decode, execute and
   response stages, one transaction in flight */

`timescale 1ns/100ps
`default_nettype none

`include "mtimer_consts.svh"

module mtimer_top import mtimer_pkg::*; (
	input  wire                            clk,
	input  wire                            rst_n,

	// write address / data / response
	input  wire                            i_s_awvalid,
	output logic                           o_s_awready,
	input  wire  [`MTIMER_ADDR_W-1:0]      i_s_awaddr,
	input  wire                            i_s_wvalid,
	output logic                           o_s_wready,
	input  wire  [`MTIMER_DATA_W-1:0]      i_s_wdata,
	input  wire  [`MTIMER_DATA_W/8-1:0]    i_s_wstrb,
	output logic                           o_s_bvalid,
	input  wire                            i_s_bready,
	output logic [1:0]                     o_s_bresp,

	// read address / data
	input  wire                            i_s_arvalid,
	output logic                           o_s_arready,
	input  wire  [`MTIMER_ADDR_W-1:0]      i_s_araddr,
	output logic                           o_s_rvalid,
	input  wire                            i_s_rready,
	output logic [`MTIMER_DATA_W-1:0]      o_s_rdata,
	output logic [1:0]                     o_s_rresp,

	// per-hart sideband
	input  wire  [`MTIMER_N_HARTS-1:0]     i_hart_halted,
	output logic [`MTIMER_N_HARTS-1:0]     o_soft_irq,
	output logic [`MTIMER_N_HARTS-1:0]     o_timer_irq
);

	// op slot, decode to execute and response
	mtimer_op_e                    op;
	mtimer_ofs_u                   ofs;
	logic [`MTIMER_DATA_W-1:0]     wdata;
	logic [`MTIMER_DATA_W/8-1:0]   wstrb;
	// execute to response
	logic [`MTIMER_DATA_W-1:0]     rdata;
	logic                          unmapped;
	// response pending, stalls decode
	logic                          busy;

	mtimer_req_decode u_req_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_s_awvalid (i_s_awvalid),
		.i_s_awaddr  (i_s_awaddr),
		.i_s_wvalid  (i_s_wvalid),
		.i_s_wdata   (i_s_wdata),
		.i_s_wstrb   (i_s_wstrb),
		.i_s_arvalid (i_s_arvalid),
		.i_s_araddr  (i_s_araddr),
		.i_busy      (busy),
		.o_s_awready (o_s_awready),
		.o_s_wready  (o_s_wready),
		.o_s_arready (o_s_arready),
		.o_op        (op),
		.o_ofs       (ofs),
		.o_wdata     (wdata),
		.o_wstrb     (wstrb)
	);

	mtimer_exec u_exec (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_op          (op),
		.i_ofs         (ofs),
		.i_wdata       (wdata),
		.i_wstrb       (wstrb),
		.i_hart_halted (i_hart_halted),
		.o_rdata       (rdata),
		.o_unmapped    (unmapped),
		.o_soft_irq    (o_soft_irq),
		.o_timer_irq   (o_timer_irq)
	);

	mtimer_resp u_resp (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_op       (op),
		.i_rdata    (rdata),
		.i_unmapped (unmapped),
		.i_s_bready (i_s_bready),
		.i_s_rready (i_s_rready),
		.o_s_bvalid (o_s_bvalid),
		.o_s_bresp  (o_s_bresp),
		.o_s_rvalid (o_s_rvalid),
		.o_s_rdata  (o_s_rdata),
		.o_s_rresp  (o_s_rresp),
		.o_busy     (busy)
	);

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
/* clock and power-on reset source for the timer testbench */

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS  = 4,
	parameter int RST_CYCLES = 4
) (
	output logic o_clk,
	output logic o_rst_n
);

	// free running, starts low
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// reset released on a rising edge after RST_CYCLES edges
	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/mtimer_tb.sv
/* testbench for the AXI4-Lite machine timer; drives register traffic and
   lets concurrent assertions check responses, interrupts and handshakes */

`timescale 1ns/100ps
`default_nettype none

`include "mtimer_consts.svh"

module mtimer_tb import mtimer_pkg::*; ();

	// read data check modes
	localparam int RD_ANY = 0;
	localparam int RD_EQ  = 1;
	localparam int RD_GE  = 2;
	localparam int RD_GT  = 3;
	localparam logic [15:0] CMP0_LO = `MTIMER_OFS_CMP_BASE;
	localparam logic [15:0] CMP0_HI = `MTIMER_OFS_CMP_BASE + 16'h4;
	localparam logic [15:0] CMP1_LO = `MTIMER_OFS_CMP_BASE + 16'h8;
	localparam logic [15:0] CMP1_HI = `MTIMER_OFS_CMP_BASE + 16'hc;
	localparam int HALT_GAP = 4 * `MTIMER_TICK_DIV;
	localparam int BP_HOLD  = 24;
	// at most 64 transfers of 12 cycles, two halt gaps, irq wait, two held responses
	localparam int TIMEOUT_CYCLES =
		2 * (64 * 12 + 2 * HALT_GAP + 8 * `MTIMER_TICK_DIV + 2 * BP_HOLD);

	logic clk;
	logic rst_n;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [`MTIMER_ADDR_W-1:0]   awaddr;
	logic [`MTIMER_ADDR_W-1:0]   araddr;
	logic [`MTIMER_DATA_W-1:0]   wdata;
	logic [`MTIMER_DATA_W/8-1:0] wstrb;
	logic [`MTIMER_DATA_W-1:0]   rdata;
	logic [1:0]                  bresp;
	logic [1:0]                  rresp;
	logic [`MTIMER_N_HARTS-1:0]  hart_halted;
	logic [`MTIMER_N_HARTS-1:0]  soft_irq;
	logic [`MTIMER_N_HARTS-1:0]  timer_irq;

	// expectations set when a request is raised
	int                          rd_mode;
	logic [`MTIMER_DATA_W-1:0]   exp_rdata;
	mtimer_resp_e                exp_rresp;
	mtimer_resp_e                exp_bresp;
	logic [`MTIMER_N_HARTS-1:0]  exp_msip;
	logic                        msip_chk;
	logic                        irq1_guard;
	logic [`MTIMER_DATA_W-1:0]   last_rdata;
	logic [`MTIMER_DATA_W-1:0]   snap;
	integer                      seed;
	int                          errors;
	int                          n_reads;
	int                          n_writes;
	int                          cycles;

	tb_clk_gen #(.PERIOD_NS(4), .RST_CYCLES(4)) u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

	mtimer_top u_mtimer_top (
		.clk(clk), .rst_n(rst_n),
		.i_s_awvalid(awvalid), .o_s_awready(awready), .i_s_awaddr(awaddr),
		.i_s_wvalid(wvalid), .o_s_wready(wready), .i_s_wdata(wdata), .i_s_wstrb(wstrb),
		.o_s_bvalid(bvalid), .i_s_bready(bready), .o_s_bresp(bresp),
		.i_s_arvalid(arvalid), .o_s_arready(arready), .i_s_araddr(araddr),
		.o_s_rvalid(rvalid), .i_s_rready(rready), .o_s_rdata(rdata), .o_s_rresp(rresp),
		.i_hart_halted(hart_halted), .o_soft_irq(soft_irq), .o_timer_irq(timer_irq)
	);

	// ----------------------------------------------------------------------
	// checks

	a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |->
		!(awready || wready || arready || bvalid || rvalid) && (soft_irq == '0) &&
		(timer_irq == '0))
	else begin
		errors = errors + 1;
		$display("Mismatch at %0t ns: handshake or irq outputs high after reset", $time);
	end

	a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
		(rvalid && rready) |-> ((rd_mode == RD_ANY) ||
		(rd_mode == RD_EQ && rdata == exp_rdata) ||
		(rd_mode == RD_GE && rdata >= exp_rdata) ||
		(rd_mode == RD_GT && rdata > exp_rdata)))
	else begin
		errors = errors + 1;
		$display("Mismatch at %0t ns: rdata %h, reference %h, mode %0d",
			$time, rdata, exp_rdata, rd_mode);
	end

	a_read_resp: assert property (@(posedge clk) disable iff (!rst_n)
		(rvalid && rready) |-> (rresp == exp_rresp))
	else begin
		errors = errors + 1;
		$display("Mismatch at %0t ns: rresp %0d, expected %0d", $time, rresp, exp_rresp);
	end

	a_write_resp: assert property (@(posedge clk) disable iff (!rst_n)
		(bvalid && bready) |-> (bresp == exp_bresp))
	else begin
		errors = errors + 1;
		$display("Mismatch at %0t ns: bresp %0d, expected %0d", $time, bresp, exp_bresp);
	end

	// msip already written by the time B is raised
	a_soft_irq: assert property (@(posedge clk) disable iff (!rst_n)
		(msip_chk && bvalid) |-> (soft_irq == exp_msip))
	else begin
		errors = errors + 1;
		$display("Mismatch at %0t ns: soft irq %b, expected %b", $time, soft_irq, exp_msip);
	end

	// hart 1 compare stays all ones from test 4 on
	a_irq1_low: assert property (@(posedge clk) disable iff (!rst_n)
		irq1_guard |-> !timer_irq[1])
	else begin
		errors = errors + 1;
		$display("Mismatch at %0t ns: timer irq 1 high with mtimecmp all ones", $time);
	end

	a_ready_block: assert property (@(posedge clk) disable iff (!rst_n)
		(bvalid || rvalid) |-> !(awready || wready || arready))
	else begin
		errors = errors + 1;
		$display("at %0t ns: a ready went high while a response was held", $time);
	end

	a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(bvalid && !bready) |=> (bvalid && $stable(bresp)))
	else begin
		errors = errors + 1;
		$display("at %0t ns: write response dropped or changed before bready", $time);
	end

	a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
	else begin
		errors = errors + 1;
		$display("at %0t ns: read response dropped or changed before rready", $time);
	end

	// ----------------------------------------------------------------------
	// bus tasks

	task automatic pick_delay(output int d);
		d = int'($unsigned($random(seed)) % 4);
	endtask

	task automatic issue_write(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input mtimer_resp_e resp);
		@(posedge clk);
		awvalid   <= 1'b1;
		awaddr    <= addr;
		wvalid    <= 1'b1;
		wdata     <= data;
		wstrb     <= strb;
		exp_bresp <= resp;
		// aw and w accepted on the same edge
		do @(negedge clk); while (!(awready && wready));
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
	endtask

	task automatic take_write_resp(input int hold);
		repeat (hold) @(posedge clk);
		bready <= 1'b1;
		do @(negedge clk); while (!bvalid);
		@(posedge clk);
		bready   <= 1'b0;
		n_writes = n_writes + 1;
	endtask

	task automatic issue_read(input logic [15:0] addr, input int mode,
		input logic [31:0] ref_val, input mtimer_resp_e resp);
		@(posedge clk);
		arvalid   <= 1'b1;
		araddr    <= addr;
		rd_mode   <= mode;
		exp_rdata <= ref_val;
		exp_rresp <= resp;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
	endtask

	task automatic take_read_data(input int hold);
		repeat (hold) @(posedge clk);
		rready <= 1'b1;
		do @(negedge clk); while (!rvalid);
		last_rdata = rdata;
		@(posedge clk);
		rready  <= 1'b0;
		n_reads = n_reads + 1;
	endtask

	task automatic reg_write(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input mtimer_resp_e resp);
		int d;
		pick_delay(d);
		issue_write(addr, data, strb, resp);
		take_write_resp(d);
	endtask

	task automatic reg_read(input logic [15:0] addr, input int mode,
		input logic [31:0] ref_val, input mtimer_resp_e resp);
		int d;
		pick_delay(d);
		issue_read(addr, mode, ref_val, resp);
		take_read_data(d);
	endtask

	// ----------------------------------------------------------------------
	// run limit

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles: %0d reads, %0d writes, %0d errors",
				cycles, n_reads, n_writes, errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// stimulus

	initial begin
		logic [31:0] first_mtime;
		seed = 32'hc7a9;
		errors = 0;
		n_reads = 0;
		n_writes = 0;
		cycles = 0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		hart_halted = '0;
		rd_mode = RD_ANY;
		exp_rdata = '0;
		exp_rresp = MTIMER_RESP_OKAY;
		exp_bresp = MTIMER_RESP_OKAY;
		exp_msip = '0;
		msip_chk = 1'b0;
		irq1_guard = 1'b0;
		wait (rst_n);

		// 1 reset values
		reg_read(`MTIMER_OFS_CTRL, RD_EQ, 32'h0, MTIMER_RESP_OKAY);
		reg_read(`MTIMER_OFS_MSIP, RD_EQ, 32'h0, MTIMER_RESP_OKAY);
		reg_read(`MTIMER_OFS_MTIME, RD_EQ, 32'h0, MTIMER_RESP_OKAY);
		reg_read(`MTIMER_OFS_MTIMEH, RD_EQ, 32'h0, MTIMER_RESP_OKAY);

		// 2 readback with counting off and partial strobes merged per byte
		reg_write(CMP0_LO, 32'h1122_3344, 4'hf, MTIMER_RESP_OKAY);
		reg_write(CMP0_HI, 32'h5566_7788, 4'hf, MTIMER_RESP_OKAY);
		reg_write(CMP1_LO, 32'h99aa_bbcc, 4'hf, MTIMER_RESP_OKAY);
		reg_write(CMP1_LO, 32'hdead_beef, 4'b0110, MTIMER_RESP_OKAY);
		reg_write(CMP1_HI, 32'h0000_0000, 4'b1000, MTIMER_RESP_OKAY);
		reg_write(`MTIMER_OFS_MTIME, 32'hcafe_f00d, 4'hf, MTIMER_RESP_OKAY);
		reg_write(`MTIMER_OFS_MTIME, 32'h1234_5678, 4'b0001, MTIMER_RESP_OKAY);
		reg_write(`MTIMER_OFS_MTIMEH, 32'hffff_0001, 4'b0011, MTIMER_RESP_OKAY);
		reg_read(CMP0_LO, RD_EQ, 32'h1122_3344, MTIMER_RESP_OKAY);
		reg_read(CMP0_HI, RD_EQ, 32'h5566_7788, MTIMER_RESP_OKAY);
		reg_read(CMP1_LO, RD_EQ, 32'h99ad_becc, MTIMER_RESP_OKAY);
		reg_read(CMP1_HI, RD_EQ, 32'h00ff_ffff, MTIMER_RESP_OKAY);
		reg_read(`MTIMER_OFS_MTIME, RD_EQ, 32'hcafe_f078, MTIMER_RESP_OKAY);
		reg_read(`MTIMER_OFS_MTIMEH, RD_EQ, 32'h0000_0001, MTIMER_RESP_OKAY);

		// 3 msip drives soft irq and ignores upper bits and empty strobes
		msip_chk <= 1'b1;
		exp_msip <= 2'b01;
		reg_write(`MTIMER_OFS_MSIP, 32'h1, 4'hf, MTIMER_RESP_OKAY);
		exp_msip <= 2'b10;
		reg_write(`MTIMER_OFS_MSIP, 32'h2, 4'hf, MTIMER_RESP_OKAY);
		exp_msip <= 2'b11;
		reg_write(`MTIMER_OFS_MSIP, 32'h3, 4'hf, MTIMER_RESP_OKAY);
		exp_msip <= 2'b00;
		reg_write(`MTIMER_OFS_MSIP, 32'h0, 4'hf, MTIMER_RESP_OKAY);
		exp_msip <= 2'b01;
		reg_write(`MTIMER_OFS_MSIP, 32'hffff_fff1, 4'b0001, MTIMER_RESP_OKAY);
		reg_write(`MTIMER_OFS_MSIP, 32'h3, 4'b0000, MTIMER_RESP_OKAY);
		reg_read(`MTIMER_OFS_MSIP, RD_EQ, 32'h1, MTIMER_RESP_OKAY);

		// 4 counting with hart 0 compare at 5 and hart 1 all ones
		reg_write(`MTIMER_OFS_MTIME, 32'h0, 4'hf, MTIMER_RESP_OKAY);
		reg_write(`MTIMER_OFS_MTIMEH, 32'h0, 4'hf, MTIMER_RESP_OKAY);
		reg_write(CMP1_LO, 32'hffff_ffff, 4'hf, MTIMER_RESP_OKAY);
		reg_write(CMP1_HI, 32'hffff_ffff, 4'hf, MTIMER_RESP_OKAY);
		reg_write(CMP0_HI, 32'h0, 4'hf, MTIMER_RESP_OKAY);
		reg_write(CMP0_LO, 32'h5, 4'hf, MTIMER_RESP_OKAY);
		irq1_guard <= 1'b1;
		reg_write(`MTIMER_OFS_CTRL, 32'h1, 4'hf, MTIMER_RESP_OKAY);
		reg_read(`MTIMER_OFS_MTIME, RD_ANY, 32'h0, MTIMER_RESP_OKAY);
		first_mtime = last_rdata;
		for (int i = 0; i < 8; i++) begin
			reg_read(`MTIMER_OFS_MTIME, RD_GE, last_rdata, MTIMER_RESP_OKAY);
		end
		// wait for mtime to reach the hart 0 compare
		while (!timer_irq[0]) @(negedge clk);
		reg_read(`MTIMER_OFS_MTIME, RD_GT, first_mtime, MTIMER_RESP_OKAY);
		reg_read(CMP0_LO, RD_EQ, 32'h5, MTIMER_RESP_OKAY);

		// 5 frozen while all harts halted and running with one awake
		@(posedge clk);
		hart_halted <= 2'b11;
		reg_read(`MTIMER_OFS_MTIME, RD_ANY, 32'h0, MTIMER_RESP_OKAY);
		snap = last_rdata;
		repeat (HALT_GAP) @(posedge clk);
		reg_read(`MTIMER_OFS_MTIME, RD_EQ, snap, MTIMER_RESP_OKAY);
		hart_halted <= 2'b01;
		reg_read(`MTIMER_OFS_MTIME, RD_ANY, 32'h0, MTIMER_RESP_OKAY);
		snap = last_rdata;
		repeat (HALT_GAP) @(posedge clk);
		reg_read(`MTIMER_OFS_MTIME, RD_GT, snap, MTIMER_RESP_OKAY);

		// 6 unmapped offsets with mtime frozen for an exact compare
		hart_halted <= 2'b11;
		reg_read(`MTIMER_OFS_MTIME, RD_ANY, 32'h0, MTIMER_RESP_OKAY);
		snap = last_rdata;
		reg_read(16'h0012, RD_EQ, 32'h0, MTIMER_RESP_SLVERR);
		reg_write(16'h0020, 32'h0, 4'hf, MTIMER_RESP_SLVERR);
		reg_write(16'h0016, 32'hffff_ffff, 4'hf, MTIMER_RESP_SLVERR);
		// held R with a write waiting and then held B with a read waiting
		issue_read(16'h0040, RD_EQ, 32'h0, MTIMER_RESP_SLVERR);
		fork
			issue_write(16'h0044, 32'hffff_ffff, 4'hf, MTIMER_RESP_SLVERR);
			take_read_data(BP_HOLD);
		join
		fork
			issue_read(`MTIMER_OFS_CTRL, RD_EQ, 32'h1, MTIMER_RESP_OKAY);
			take_write_resp(BP_HOLD);
		join
		take_read_data(1);
		reg_read(`MTIMER_OFS_MSIP, RD_EQ, 32'h1, MTIMER_RESP_OKAY);
		reg_read(CMP0_LO, RD_EQ, 32'h5, MTIMER_RESP_OKAY);
		reg_read(CMP0_HI, RD_EQ, 32'h0, MTIMER_RESP_OKAY);
		reg_read(CMP1_LO, RD_EQ, 32'hffff_ffff, MTIMER_RESP_OKAY);
		reg_read(CMP1_HI, RD_EQ, 32'hffff_ffff, MTIMER_RESP_OKAY);
		reg_read(`MTIMER_OFS_MTIME, RD_EQ, snap, MTIMER_RESP_OKAY);

		repeat (4) @(posedge clk);
		$display("run complete: %0d reads, %0d writes, %0d errors", n_reads, n_writes, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/mtimer_pkg.sv
hw/mtimer_req_decode.sv
hw/mtimer_exec.sv
hw/mtimer_resp.sv
hw/mtimer_top.sv
dv/tb_clk_gen.sv
dv/mtimer_tb.sv

// File: Makefile
# Verilator build and run of the machine timer testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= mtimer_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
